// File: hdl/ttc_pkg.sv
package ttc_pkg;

   // --------------------
   // Sizes and counts
   // --------------------
   localparam int n_timers     = 3;
   localparam int timer_stride = 32;                     // Bytes per timer block
   localparam int addr_w       = 8;                      // APB address width
   localparam int data_w       = 32;                     // APB data width
   localparam int off_w        = $clog2(timer_stride);   // Offset bits within a block
   localparam int idx_w        = addr_w - off_w;         // Timer index bits
   localparam int cnt_w        = 16;                     // Counter, interval, match
   localparam int clk_ctrl_w   = 5;
   localparam int cntr_ctrl_w  = 5;
   localparam int int_w        = 3;

   // Clock control fields
   localparam int ps_en_bit  = 0;                        // Prescale enable
   localparam int ps_exp_lsb = 1;                        // Exponent in bits 4..1
   localparam int ps_exp_w   = clk_ctrl_w - ps_exp_lsb;

   // Counter control fields
   localparam int ctrl_disable  = 0;
   localparam int ctrl_interval = 1;                     // Interval mode, else overflow
   localparam int ctrl_decr     = 2;
   localparam int ctrl_match_en = 3;
   localparam int ctrl_cnt_rst  = 4;                     // Self-clearing, reads 0

   localparam logic [cntr_ctrl_w-1:0] cntr_ctrl_rst = 5'b00001;  // Disabled out of reset

   // Interrupt status / enable bits
   localparam int int_interval = 0;
   localparam int int_match    = 1;
   localparam int int_overflow = 2;

   // --------------------
   // Register map
   // --------------------
   localparam logic [off_w-1:0] off_clk_ctrl   = 5'h00;
   localparam logic [off_w-1:0] off_cntr_ctrl  = 5'h04;
   localparam logic [off_w-1:0] off_counter    = 5'h08;  // Read only
   localparam logic [off_w-1:0] off_interval   = 5'h0C;
   localparam logic [off_w-1:0] off_match      = 5'h10;
   localparam logic [off_w-1:0] off_int_status = 5'h14;  // Read only, clear on read
   localparam logic [off_w-1:0] off_int_en     = 5'h18;

   // Per-timer write / clear strobes
   typedef struct packed {
      logic clk_ctrl;
      logic cntr_ctrl;
      logic interval;
      logic match;
      logic int_en;
      logic clear_int;                                   // Status read in access phase
   } ttc_sel_t;

   // Per-timer readback bundle
   typedef struct packed {
      logic [clk_ctrl_w-1:0]  clk_ctrl;
      logic [cntr_ctrl_w-1:0] cntr_ctrl;
      logic [cnt_w-1:0]       counter;
      logic [cnt_w-1:0]       interval;
      logic [cnt_w-1:0]       match;
      logic [int_w-1:0]       int_status;
      logic [int_w-1:0]       int_en;
   } ttc_regs_t;

endpackage

// File: hdl/ttc_prescaler.sv
`timescale 1ns/1ps

module ttc_prescaler (
   input  logic                             pclk,
   input  logic                             rst,
   input  logic [ttc_pkg::clk_ctrl_w-1:0]   clk_ctrl,
   output logic                             tick
);

   logic [ttc_pkg::cnt_w-1:0]       div_cnt;      // Free-running divider
   logic [ttc_pkg::cnt_w-1:0]       div_mask;     // Low p+1 bits set
   logic [ttc_pkg::clk_ctrl_w-1:0]  clk_ctrl_q;   // Last seen setting
   logic [ttc_pkg::ps_exp_w-1:0]    ps_exp;
   logic                            pre_en;
   logic                            stable;

   assign pre_en = clk_ctrl[ttc_pkg::ps_en_bit];
   assign ps_exp = clk_ctrl[ttc_pkg::clk_ctrl_w-1:ttc_pkg::ps_exp_lsb];

   // Period 2**(p+1) when low bits all ones
   assign div_mask = {ttc_pkg::cnt_w{1'b1}} >> (ttc_pkg::cnt_w - 1 - int'(ps_exp));
   assign stable   = (clk_ctrl == clk_ctrl_q);

   // No tick in the cycle a new setting lands
   assign tick = ~pre_en | (stable & ((div_cnt & div_mask) == div_mask));

   always_ff @(posedge pclk) begin
      if (rst) begin
         div_cnt    <= '0;
         clk_ctrl_q <= '0;
      end else begin
         clk_ctrl_q <= clk_ctrl;
         if (!stable) begin
            div_cnt <= '0;                    // Restart on setting change
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

endmodule

// File: hdl/ttc_timer_counter.sv
`timescale 1ns/1ps

module ttc_timer_counter (
   input  logic                        pclk,
   input  logic                        rst,
   input  logic [ttc_pkg::cnt_w-1:0]   wdata,      // Low bits of pwdata
   input  ttc_pkg::ttc_sel_t           sel,
   output ttc_pkg::ttc_regs_t          regs,
   output logic                        interrupt
);

   logic [ttc_pkg::clk_ctrl_w-1:0]   clk_ctrl_q;
   logic [ttc_pkg::cntr_ctrl_w-2:0]  cntr_ctrl_q;  // Bit 4 never stored
   logic [ttc_pkg::cnt_w-1:0]        counter_q;
   logic [ttc_pkg::cnt_w-1:0]        interval_q;
   logic [ttc_pkg::cnt_w-1:0]        match_q;
   logic [ttc_pkg::int_w-1:0]        int_status_q;
   logic [ttc_pkg::int_w-1:0]        int_en_q;

   logic                             tick;
   logic                             step;         // Counter advances this edge
   logic                             cnt_rst_wr;   // Counter reset written
   logic                             intv_mode;
   logic                             decr;
   logic [ttc_pkg::cnt_w-1:0]        cnt_next;
   logic [ttc_pkg::int_w-1:0]        evt;          // Events if stepping
   logic [ttc_pkg::int_w-1:0]        step_evt;

   ttc_prescaler u_prescaler (
      .pclk     (pclk),
      .rst      (rst),
      .clk_ctrl (clk_ctrl_q),
      .tick     (tick)
   );

   assign intv_mode  = cntr_ctrl_q[ttc_pkg::ctrl_interval];
   assign decr       = cntr_ctrl_q[ttc_pkg::ctrl_decr];
   assign step       = tick & ~cntr_ctrl_q[ttc_pkg::ctrl_disable];
   assign cnt_rst_wr = sel.cntr_ctrl & wdata[ttc_pkg::ctrl_cnt_rst];

   // --------------------
   // Next count and events
   // --------------------
   always_comb begin
      cnt_next = counter_q;
      evt      = '0;
      if (decr) begin
         if (counter_q == '0) begin
            if (intv_mode) begin
               cnt_next                  = interval_q;   // Reload
               evt[ttc_pkg::int_interval] = 1'b1;
            end else begin
               cnt_next                  = '1;           // Underflow wrap
               evt[ttc_pkg::int_overflow] = 1'b1;
            end
         end else begin
            cnt_next = counter_q - 1'b1;
         end
      end else begin
         if (intv_mode && (counter_q >= interval_q)) begin
            cnt_next                  = '0;              // Interval reached
            evt[ttc_pkg::int_interval] = 1'b1;
         end else if (!intv_mode && (counter_q == '1)) begin
            cnt_next                  = '0;              // 16-bit wrap
            evt[ttc_pkg::int_overflow] = 1'b1;
         end else begin
            cnt_next = counter_q + 1'b1;
         end
      end
      // Match on the new value
      if (cntr_ctrl_q[ttc_pkg::ctrl_match_en] && (cnt_next == match_q)) begin
         evt[ttc_pkg::int_match] = 1'b1;
      end
   end

   // Counter reset write takes the edge, no events then
   assign step_evt = (step && !cnt_rst_wr) ? evt : '0;

   // --------------------
   // Registers
   // --------------------
   always_ff @(posedge pclk) begin
      if (rst) begin
         clk_ctrl_q  <= '0;
         cntr_ctrl_q <= ttc_pkg::cntr_ctrl_rst[ttc_pkg::cntr_ctrl_w-2:0];
         interval_q  <= '0;
         match_q     <= '0;
         int_en_q    <= '0;
      end else begin
         if (sel.clk_ctrl) begin
            clk_ctrl_q <= wdata[ttc_pkg::clk_ctrl_w-1:0];
         end
         if (sel.cntr_ctrl) begin
            cntr_ctrl_q <= wdata[ttc_pkg::cntr_ctrl_w-2:0];  // Self-clearing bit dropped
         end
         if (sel.interval) begin
            interval_q <= wdata;
         end
         if (sel.match) begin
            match_q <= wdata;
         end
         if (sel.int_en) begin
            int_en_q <= wdata[ttc_pkg::int_w-1:0];
         end
      end
   end

   // Counter, reload value follows the newly written direction
   always_ff @(posedge pclk) begin
      if (rst) begin
         counter_q <= '0;
      end else if (cnt_rst_wr) begin
         counter_q <= wdata[ttc_pkg::ctrl_decr] ? interval_q : '0;
      end else if (step) begin
         counter_q <= cnt_next;
      end
   end

   // Status, a new event wins over the read clear
   always_ff @(posedge pclk) begin
      if (rst) begin
         int_status_q <= '0;
      end else begin
         int_status_q <= (sel.clear_int ? '0 : int_status_q) | step_evt;
      end
   end

   assign interrupt = |(int_status_q & int_en_q);   // No extra delay

   // Readback
   assign regs.clk_ctrl   = clk_ctrl_q;
   assign regs.cntr_ctrl  = {1'b0, cntr_ctrl_q};     // Counter reset reads 0
   assign regs.counter    = counter_q;
   assign regs.interval   = interval_q;
   assign regs.match      = match_q;
   assign regs.int_status = int_status_q;
   assign regs.int_en     = int_en_q;

endmodule

// File: hdl/ttc_apb_if.sv
`timescale 1ns/1ps

module ttc_apb_if (
   input  logic                                     pclk,
   input  logic                                     rst,
   input  logic                                     psel,
   input  logic                                     penable,
   input  logic                                     pwrite,
   input  logic [ttc_pkg::addr_w-1:0]               paddr,
   input  ttc_pkg::ttc_regs_t [ttc_pkg::n_timers-1:0] regs,
   output logic [ttc_pkg::data_w-1:0]               prdata,
   output ttc_pkg::ttc_sel_t  [ttc_pkg::n_timers-1:0] sel
);

   logic                       setup_q;   // Previous cycle was a setup phase
   logic                       access;
   logic                       wr_acc;
   logic                       rd_acc;
   logic [ttc_pkg::idx_w-1:0]  idx;       // Timer index
   logic [ttc_pkg::off_w-1:0]  off;       // Register offset in block

   // --------------------
   // Phase tracking
   // --------------------

   // Access phase only counts when it follows a setup phase,
   // so each transfer gives exactly one strobe
   always_ff @(posedge pclk) begin
      if (rst) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= psel & ~penable;
      end
   end

   assign access = psel & penable & setup_q;
   assign wr_acc = access & pwrite;
   assign rd_acc = access & ~pwrite;

   // Address split
   assign idx = paddr[ttc_pkg::addr_w-1:ttc_pkg::off_w];
   assign off = paddr[ttc_pkg::off_w-1:0];

   // --------------------
   // Write decode
   // --------------------
   always_comb begin
      for (int k = 0; k < ttc_pkg::n_timers; k++) begin
         sel[k] = '0;
         if (idx == k) begin
            sel[k].clk_ctrl  = wr_acc && (off == ttc_pkg::off_clk_ctrl);
            sel[k].cntr_ctrl = wr_acc && (off == ttc_pkg::off_cntr_ctrl);
            sel[k].interval  = wr_acc && (off == ttc_pkg::off_interval);
            sel[k].match     = wr_acc && (off == ttc_pkg::off_match);
            sel[k].int_en    = wr_acc && (off == ttc_pkg::off_int_en);
            // Status read clears it at this edge
            sel[k].clear_int = rd_acc && (off == ttc_pkg::off_int_status);
         end
      end
   end

   // --------------------
   // Read mux
   // --------------------

   // Zero outside access, zero for unused offsets and index 3
   always_comb begin
      prdata = '0;
      for (int k = 0; k < ttc_pkg::n_timers; k++) begin
         if (rd_acc && (idx == k)) begin
            case (off)
               ttc_pkg::off_clk_ctrl: begin
                  prdata[ttc_pkg::clk_ctrl_w-1:0] = regs[k].clk_ctrl;
               end
               ttc_pkg::off_cntr_ctrl: begin
                  prdata[ttc_pkg::cntr_ctrl_w-1:0] = regs[k].cntr_ctrl;
               end
               ttc_pkg::off_counter: begin
                  prdata[ttc_pkg::cnt_w-1:0] = regs[k].counter;
               end
               ttc_pkg::off_interval: begin
                  prdata[ttc_pkg::cnt_w-1:0] = regs[k].interval;
               end
               ttc_pkg::off_match: begin
                  prdata[ttc_pkg::cnt_w-1:0] = regs[k].match;
               end
               ttc_pkg::off_int_status: begin
                  prdata[ttc_pkg::int_w-1:0] = regs[k].int_status;
               end
               ttc_pkg::off_int_en: begin
                  prdata[ttc_pkg::int_w-1:0] = regs[k].int_en;
               end
               default: begin
                  prdata = '0;              // Hole in the map
               end
            endcase
         end
      end
   end

endmodule

// File: hdl/ttc_lite.sv
`timescale 1ns/1ps

module ttc_lite (
   input  logic                            pclk,
   input  logic                            rst,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [ttc_pkg::addr_w-1:0]      paddr,
   input  logic [ttc_pkg::data_w-1:0]      pwdata,
   output logic [ttc_pkg::data_w-1:0]      prdata,
   output logic [ttc_pkg::n_timers-1:0]    interrupt   // One bit per timer
);

   ttc_pkg::ttc_sel_t  [ttc_pkg::n_timers-1:0] sel;     // Decode to timers
   ttc_pkg::ttc_regs_t [ttc_pkg::n_timers-1:0] regs;    // Timers to read mux

   // --------------------
   // APB decode and read mux
   // --------------------
   ttc_apb_if u_apb_if (
      .pclk    (pclk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .regs    (regs),
      .prdata  (prdata),
      .sel     (sel)
   );

   // --------------------
   // Timers
   // --------------------
   for (genvar k = 0; k < ttc_pkg::n_timers; k++) begin : g_timer
      ttc_timer_counter u_timer (
         .pclk      (pclk),
         .rst       (rst),
         .wdata     (pwdata[ttc_pkg::cnt_w-1:0]),   // Registers are 16 bits at most
         .sel       (sel[k]),
         .regs      (regs[k]),
         .interrupt (interrupt[k])
      );
   end

endmodule

// File: verif/ttc_lite_asserts.sv
`timescale 1ns/1ps

module ttc_lite_asserts (
   input logic                                      pclk,
   input logic                                      rst,
   input logic                                      psel,
   input logic                                      penable,
   input logic [ttc_pkg::data_w-1:0]                prdata,
   input logic [ttc_pkg::n_timers-1:0]              interrupt,
   input ttc_pkg::ttc_sel_t [ttc_pkg::n_timers-1:0] sel
);

   int   prdata_errs = 0;                        // Failure counts per property
   int   irq_errs    = 0;
   int   sel_errs    = 0;
   logic sel_ok;

   // No timer sees two strobes at once
   always_comb begin
      sel_ok = 1'b1;
      for (int k = 0; k < ttc_pkg::n_timers; k++) begin
         if (!$onehot0(sel[k])) begin
            sel_ok = 1'b0;
         end
      end
   end

   // Read bus idle outside the access phase
   prdata_idle: assert property (@(posedge pclk) disable iff (rst)
      !(psel && penable) |-> (prdata == '0))
      else begin
         $error("prdata nonzero outside the access phase");
         prdata_errs++;
      end

   // Quiet interrupts just out of reset
   irq_after_rst: assert property (@(posedge pclk) disable iff (rst)
      ($past(rst) || $past(rst, 2)) |-> (interrupt == '0))
      else begin
         $error("interrupt raised right after reset");
         irq_errs++;
      end

   sel_onehot: assert property (@(posedge pclk) disable iff (rst) sel_ok)
      else begin
         $error("more than one select strobe for a timer");
         sel_errs++;
      end

endmodule

// File: verif/ttc_lite_tb.sv
`timescale 1ns/1ps

module ttc_lite_tb;

   logic        pclk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic [2:0]  interrupt;

   int seed = 32'hc5a0;                          // Fixed stimulus seed

   ttc_lite dut0 (
      .pclk      (pclk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   bind ttc_lite ttc_lite_asserts u_asserts (
      .pclk      (pclk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .prdata    (prdata),
      .interrupt (interrupt),
      .sel       (sel)
   );

   always #2 pclk = ~pclk;                       // 4 ns period

   // --------------------
   // APB tasks
   // --------------------
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge pclk);
      psel    <= 1'b1;                           // Setup
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge pclk);
      penable <= 1'b1;                           // Access
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge pclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge pclk);
      penable <= 1'b1;
      @(negedge pclk);
      data = prdata;                             // Mid access phase
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   function automatic logic [7:0] reg_addr(input int t, input logic [4:0] off);
      return 8'(t * ttc_pkg::timer_stride) | {3'b000, off};
   endfunction

   // Expected readback from the register map rules
   function automatic logic [31:0] ref_readback(input logic [4:0] offset,
                                                input logic [31:0] written,
                                                input bit from_reset);
      if (from_reset) begin
         return (offset == ttc_pkg::off_cntr_ctrl) ? 32'h1 : 32'h0;   // Disable set
      end
      case (offset)
         ttc_pkg::off_clk_ctrl:  return written & 32'h1F;
         ttc_pkg::off_cntr_ctrl: return written & 32'h0F;            // Counter reset reads 0
         ttc_pkg::off_interval:  return written & 32'hFFFF;
         ttc_pkg::off_match:     return written & 32'hFFFF;
         ttc_pkg::off_int_en:    return written & 32'h7;
         default:                return 32'h0;
      endcase
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out waiting for %s", what);
      $display("Test failed");
      $fatal(1, "Stopped on a timeout");
   endtask

   task automatic expect_reg(input string name, input int t, input logic [4:0] off,
                             input logic [31:0] expected);
      logic [31:0] rd;
      apb_read(reg_addr(t, off), rd);
      check(name, expected, rd);
   endtask

   task automatic write_and_verify(input string name, input int t, input logic [4:0] off,
                                   input logic [31:0] data);
      apb_write(reg_addr(t, off), data);
      expect_reg(name, t, off, ref_readback(off, data, 1'b0));
   endtask

   // Poll one interrupt bit, the others must stay low
   task automatic wait_irq(input int t, input int limit);
      int n;
      n = 0;
      while (interrupt[t] !== 1'b1) begin
         if (n == limit) begin
            report_timeout($sformatf("the interrupt of timer %0d", t));
         end
         @(negedge pclk);
         check("other interrupts quiet", 32'h0, interrupt & ~(3'b001 << t));
         n++;
      end
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      int          t3;
      int          t4;
      int          t5;
      int          n;
      int          asrt_errs;
      logic [31:0] v;
      logic [31:0] rd;
      logic [31:0] rd2;
      logic [31:0] intv;
      logic [31:0] mt;

      pclk    = 1'b0;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (2) @(posedge pclk);
      rst <= 1'b0;

      // Reset values
      for (int t = 0; t < 3; t++) begin
         for (int o = 0; o < 7; o++) begin
            expect_reg("reset value", t, 5'(o * 4), ref_readback(5'(o * 4), 32'h0, 1'b1));
         end
      end
      check("reset interrupt", 32'h0, interrupt);

      // Random register writes, timers kept disabled
      for (int t = 0; t < 3; t++) begin
         for (int r = 0; r < 4; r++) begin
            write_and_verify("clk_ctrl", t, ttc_pkg::off_clk_ctrl, $random(seed));
            v = $random(seed) | 32'h1;
            write_and_verify("cntr_ctrl", t, ttc_pkg::off_cntr_ctrl, v);
            write_and_verify("interval", t, ttc_pkg::off_interval, $random(seed));
            write_and_verify("match", t, ttc_pkg::off_match, $random(seed));
            write_and_verify("int_en", t, ttc_pkg::off_int_en, $random(seed));
            write_and_verify("unused offset", t, 5'h1C, $random(seed));
         end
         check("interrupt while disabled", 32'h0, interrupt);
         apb_write(reg_addr(t, ttc_pkg::off_clk_ctrl), 32'h0);
         apb_write(reg_addr(t, ttc_pkg::off_cntr_ctrl), 32'h11);   // Zero count, stay off
         apb_write(reg_addr(t, ttc_pkg::off_int_en), 32'h0);
         apb_write(reg_addr(t, ttc_pkg::off_match), 32'h0);
      end

      // Interval mode, up, no prescale
      t3   = $unsigned($random(seed)) % 3;
      intv = 4 + ($unsigned($random(seed)) % 8);
      apb_write(reg_addr(t3, ttc_pkg::off_interval), intv);
      apb_write(reg_addr(t3, ttc_pkg::off_int_en), 32'h1);
      apb_write(reg_addr(t3, ttc_pkg::off_cntr_ctrl), 32'h12);
      wait_irq(t3, 100);
      apb_write(reg_addr(t3, ttc_pkg::off_cntr_ctrl), 32'h03);     // Stop, keep mode
      expect_reg("interval status", t3, ttc_pkg::off_int_status, 32'h1);
      expect_reg("status cleared", t3, ttc_pkg::off_int_status, 32'h0);
      @(negedge pclk);
      check("interval interrupt falls", 32'h0, interrupt[t3]);
      check("other timers quiet", 32'h0, interrupt & ~(3'b001 << t3));

      // Match while counting down, tick every 4 cycles
      t4   = (t3 + 1) % 3;
      intv = 24 + ($unsigned($random(seed)) % 16);
      mt   = 8 + ($unsigned($random(seed)) % 8);                   // Well inside interval
      apb_write(reg_addr(t4, ttc_pkg::off_clk_ctrl), 32'h03);
      apb_write(reg_addr(t4, ttc_pkg::off_interval), intv);
      apb_write(reg_addr(t4, ttc_pkg::off_match), mt);
      apb_write(reg_addr(t4, ttc_pkg::off_int_en), 32'h2);
      apb_write(reg_addr(t4, ttc_pkg::off_cntr_ctrl), 32'h1E);     // Load interval, run
      wait_irq(t4, 400);
      apb_write(reg_addr(t4, ttc_pkg::off_cntr_ctrl), 32'h0F);
      apb_read(reg_addr(t4, ttc_pkg::off_int_status), rd);
      check("match status", 32'h2, rd);                            // Zero never reached
      apb_read(reg_addr(t4, ttc_pkg::off_counter), rd);
      apb_read(reg_addr(t4, ttc_pkg::off_counter), rd2);
      check("counter frozen", rd, rd2);
      check("counter within interval", 32'h1, 32'(rd <= intv));

      // Overflow with the enable masked
      t5 = (t3 + 2) % 3;
      apb_write(reg_addr(t5, ttc_pkg::off_interval), 32'h0);
      apb_write(reg_addr(t5, ttc_pkg::off_cntr_ctrl), 32'h14);     // Down from 0, wraps
      n  = 0;
      rd = 32'h0;
      while (rd[15:8] != 8'hFF) begin
         if (n == 50) begin
            report_timeout("the counter to wrap");
         end
         apb_read(reg_addr(t5, ttc_pkg::off_counter), rd);
         check("masked overflow interrupt", 32'h0, interrupt[t5]);
         n++;
      end
      apb_write(reg_addr(t5, ttc_pkg::off_cntr_ctrl), 32'h05);
      expect_reg("overflow status", t5, ttc_pkg::off_int_status, 32'h4);
      check("masked overflow interrupt", 32'h0, interrupt[t5]);
      apb_write(reg_addr(t5, ttc_pkg::off_cntr_ctrl), 32'h11);     // Counter reset, up
      expect_reg("counter after reset", t5, ttc_pkg::off_counter, 32'h0);

      asrt_errs = dut0.u_asserts.prdata_errs + dut0.u_asserts.irq_errs
                + dut0.u_asserts.sel_errs;
      if (asrt_errs == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("Assertions failed %0d times during the run", asrt_errs);
         $display("Test failed");
         $fatal(1, "Stopped on assertion failures");
      end
   end

endmodule

// File: vlog.f
hdl/ttc_pkg.sv
hdl/ttc_prescaler.sv
hdl/ttc_timer_counter.sv
hdl/ttc_apb_if.sv
hdl/ttc_lite.sv
verif/ttc_lite_asserts.sv
verif/ttc_lite_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ttc_lite_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: pass message not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
